// File: Makefile
# Verilator build and run for the tube display peripheral

VERILATOR ?= verilator
TOP       ?= tube_display_tb
RTL_TOP   ?= tube_display_top
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall

SOURCES := $(wildcard logic/*.sv tests/*.sv)

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "SIMULATION PASSED" $(LOG) || { echo "simulation did not pass, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: list.f
logic/tube_pkg.sv
logic/tube_bus_regs.sv
logic/refresh_ticker.sv
logic/bcd_converter.sv
logic/digit_scanner.sv
logic/tube_display_top.sv
tests/tube_display_tb.sv

// File: logic/bcd_converter.sv
`timescale 1ns/1ns

module bcd_converter import tube_pkg::*; (
    input  logic                   clk_tube,
    input  logic                   rst_n,
    input  logic                   start,
    input  logic [value_width-1:0] value,
    output logic                   busy,
    output logic                   done,
    output logic [bcd_width-1:0]   digits
);

    logic [value_width-1:0]         shift_q;
    logic [bcd_width-1:0]           bcd_q;
    logic [bcd_width-1:0]           bcd_adj;
    logic [bcd_width-1:0]           bcd_next;
    logic [$clog2(value_width)-1:0] step;
    logic                           last;

    // add three to every digit that would overflow on the next shift
    always_comb begin
        for (int d = 0; d < digit_count; d++) begin
            if (bcd_q[4*d +: 4] >= 4'd5) begin
                bcd_adj[4*d +: 4] = bcd_q[4*d +: 4] + 4'd3;
            end else begin
                bcd_adj[4*d +: 4] = bcd_q[4*d +: 4];
            end
        end
    end

    // the top digit's carry falls off, which leaves value mod 10^8
    assign bcd_next = {bcd_adj[bcd_width-2:0], shift_q[value_width-1]};
    assign last     = (step == $bits(step)'(value_width - 1));

    always_ff @(posedge clk_tube or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
            done <= 1'b0;
            step <= '0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy <= 1'b1;   // restart drops any conversion in flight
                step <= '0;
            end else if (busy) begin
                step <= step + 1'b1;
                if (last) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk_tube) begin
        if (start) begin
            shift_q <= value;
            bcd_q   <= '0;
        end else if (busy) begin
            shift_q <= shift_q << 1;
            bcd_q   <= bcd_next;
            if (last) begin
                digits <= bcd_next;   // publish with the final shift
            end
        end
    end

    // a start never lets the old conversion finish on the next edge
    restart_not_lost: assert property (
        @(posedge clk_tube) disable iff (!rst_n)
        start |=> (busy && !done)
    );

endmodule

// File: logic/digit_scanner.sv
`timescale 1ns/1ns

module digit_scanner import tube_pkg::*; (
    input  logic                   clk_tube,
    input  logic                   rst_n,
    input  logic                   tick,
    input  logic                   done,
    input  logic [bcd_width-1:0]   digits,
    input  logic [value_width-1:0] value,
    input  logic                   display_enable,
    input  logic                   hex_mode,
    output logic [seg_width-1:0]   seg_tube,
    output logic [digit_count-1:0] seg_enable
);

    logic [bcd_width-1:0] snap;
    logic [pos_width-1:0] pos;
    logic [pos_width-1:0] digit_idx;
    logic [pos_width-1:0] msd;
    logic [3:0]           nibble;
    logic                 lit;

    // active-low segments, bit 6 is g and bit 0 is a
    function automatic logic [seg_width-1:0] glyph(input logic [3:0] d);
        logic [seg_width-1:0] g;
        case (d)
            4'h0:    g = 7'b1000000;
            4'h1:    g = 7'b1111001;
            4'h2:    g = 7'b0100100;
            4'h3:    g = 7'b0110000;
            4'h4:    g = 7'b0011001;
            4'h5:    g = 7'b0010010;
            4'h6:    g = 7'b0000010;
            4'h7:    g = 7'b1111000;
            4'h8:    g = 7'b0000000;
            4'h9:    g = 7'b0010000;
            4'ha:    g = 7'b0001000;
            4'hb:    g = 7'b0000011;
            4'hc:    g = 7'b1000110;
            4'hd:    g = 7'b0100001;
            4'he:    g = 7'b0000110;
            default: g = 7'b0001110;   // F
        endcase
        return g;
    endfunction

    // position 0 is the leftmost digit, which is digit 7 counted from the right
    assign digit_idx = pos_width'(digit_count - 1) - pos;

    always_comb begin
        msd = '0;
        for (int d = 1; d < digit_count; d++) begin
            if (snap[4*d +: 4] != 4'd0) begin
                msd = pos_width'(d);
            end
        end
    end

    assign nibble = hex_mode ? value[4*digit_idx +: 4] : snap[4*digit_idx +: 4];
    assign lit    = hex_mode || (digit_idx <= msd);   // units digit always passes

    always_ff @(posedge clk_tube or negedge rst_n) begin
        if (!rst_n) begin
            snap <= '0;
        end else if (done) begin
            snap <= digits;
        end
    end

    always_ff @(posedge clk_tube or negedge rst_n) begin
        if (!rst_n) begin
            pos <= '0;
        end else if (tick) begin
            pos <= pos + 1'b1;   // wraps from 7 to 0
        end
    end

    always_ff @(posedge clk_tube or negedge rst_n) begin
        if (!rst_n) begin
            seg_tube   <= '1;
            seg_enable <= '1;
        end else if (!display_enable) begin
            seg_tube   <= '1;
            seg_enable <= '1;
        end else if (tick) begin
            // a blanked position keeps its enable with no segments lit
            seg_enable <= ~(digit_count'(1) << digit_idx);
            seg_tube   <= lit ? glyph(nibble) : '1;
        end
    end

    // one position at a time on the tube
    one_digit_enabled: assert property (
        @(posedge clk_tube) disable iff (!rst_n)
        $countones(~seg_enable) <= 1
    );

endmodule

// File: logic/refresh_ticker.sv
`timescale 1ns/1ns

module refresh_ticker import tube_pkg::*; #(
    parameter int TICK_PERIOD = default_tick_period
) (
    input  logic clk_tube,
    input  logic rst_n,
    output logic tick
);

    logic [31:0] count;

    always_ff @(posedge clk_tube or negedge rst_n) begin
        if (!rst_n) begin
            count <= 32'(TICK_PERIOD - 1);
            tick  <= 1'b0;
        end else begin
            tick <= (count == '0);
            if (count == '0) begin
                count <= 32'(TICK_PERIOD - 1);   // reload
            end else begin
                count <= count - 1'b1;
            end
        end
    end

    // a tick is a single-cycle strobe unless every cycle is a tick
    tick_single_cycle: assert property (
        @(posedge clk_tube) disable iff (!rst_n || TICK_PERIOD <= 1)
        tick |=> !tick
    );

endmodule

// File: logic/tube_bus_regs.sv
`timescale 1ns/1ns

module tube_bus_regs import tube_pkg::*; (
    input  logic                   clk_tube,
    input  logic                   rst_n,
    input  logic                   wb_cyc,
    input  logic                   wb_stb,
    input  logic                   wb_we,
    input  logic [addr_width-1:0]  wb_adr,
    input  logic [value_width-1:0] wb_dat_w,
    input  logic [sel_width-1:0]   wb_sel,
    output logic [value_width-1:0] wb_dat_r,
    output logic                   wb_ack,
    input  logic                   busy,
    output logic [value_width-1:0] value,
    output logic                   display_enable,
    output logic                   hex_mode,
    output logic                   start
);

    logic                   req;
    logic                   value_wr;
    logic                   ctrl_wr;
    logic                   overflow;
    logic [value_width-1:0] ctrl_reg;
    logic [value_width-1:0] status_word;

    assign req      = wb_cyc && wb_stb && !wb_ack;   // one ack per strobe
    assign value_wr = req && wb_we && (wb_adr == addr_value);
    assign ctrl_wr  = req && wb_we && (wb_adr == addr_ctrl);
    assign overflow = (value >= value_modulus);

    assign display_enable = ctrl_reg[ctrl_enable_bit];
    assign hex_mode       = ctrl_reg[ctrl_hex_bit];

    always_comb begin
        status_word                  = '0;
        status_word[status_busy_bit] = busy;
        status_word[status_ovf_bit]  = overflow;
    end

    always_ff @(posedge clk_tube or negedge rst_n) begin
        if (!rst_n) begin
            value    <= '0;
            ctrl_reg <= '0;
        end else begin
            for (int i = 0; i < sel_width; i++) begin
                if (value_wr && wb_sel[i]) begin
                    value[8*i +: 8] <= wb_dat_w[8*i +: 8];
                end
                if (ctrl_wr && wb_sel[i]) begin
                    ctrl_reg[8*i +: 8] <= wb_dat_w[8*i +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk_tube or negedge rst_n) begin
        if (!rst_n) begin
            wb_ack   <= 1'b0;
            wb_dat_r <= '0;
            start    <= 1'b0;
        end else begin
            wb_ack <= req;
            start  <= value_wr;   // high while the write is acked
            if (req && !wb_we) begin
                case (wb_adr)
                    addr_value:  wb_dat_r <= value;
                    addr_ctrl:   wb_dat_r <= ctrl_reg;
                    addr_status: wb_dat_r <= status_word;
                    default:     wb_dat_r <= '0;   // unmapped, still acked
                endcase
            end
        end
    end

    // ack only answers a strobe seen on the previous edge
    ack_follows_strobe: assert property (
        @(posedge clk_tube) disable iff (!rst_n)
        wb_ack |-> $past(wb_cyc && wb_stb)
    );

endmodule

// File: logic/tube_display_top.sv
`timescale 1ns/1ns

module tube_display_top import tube_pkg::*; #(
    parameter int TICK_PERIOD = default_tick_period
) (
    input  logic                   clk_tube,
    input  logic                   rst_n,
    input  logic                   wb_cyc,
    input  logic                   wb_stb,
    input  logic                   wb_we,
    input  logic [addr_width-1:0]  wb_adr,
    input  logic [value_width-1:0] wb_dat_w,
    input  logic [sel_width-1:0]   wb_sel,
    output logic [value_width-1:0] wb_dat_r,
    output logic                   wb_ack,
    output logic [seg_width-1:0]   seg_tube,
    output logic [digit_count-1:0] seg_enable
);

    logic [value_width-1:0] value;
    logic [bcd_width-1:0]   digits;
    logic                   display_enable;
    logic                   hex_mode;
    logic                   start;
    logic                   busy;
    logic                   done;
    logic                   tick;

    tube_bus_regs u_regs (
        .clk_tube(clk_tube), .rst_n(rst_n),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w), .wb_sel(wb_sel), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
        .busy(busy), .value(value), .display_enable(display_enable),
        .hex_mode(hex_mode), .start(start)
    );

    bcd_converter u_bcd (
        .clk_tube(clk_tube), .rst_n(rst_n), .start(start), .value(value),
        .busy(busy), .done(done), .digits(digits)
    );

    refresh_ticker #(
        .TICK_PERIOD(TICK_PERIOD)
    ) u_ticker (
        .clk_tube(clk_tube), .rst_n(rst_n), .tick(tick)
    );

    digit_scanner u_scanner (
        .clk_tube(clk_tube), .rst_n(rst_n), .tick(tick), .done(done),
        .digits(digits), .value(value), .display_enable(display_enable),
        .hex_mode(hex_mode), .seg_tube(seg_tube), .seg_enable(seg_enable)
    );

endmodule

// File: logic/tube_pkg.sv
package tube_pkg;

    // data path widths
    localparam int value_width = 32;
    localparam int digit_count = 8;
    localparam int bcd_width   = 4 * digit_count;
    localparam int seg_width   = 7;
    localparam int sel_width   = value_width / 8;
    localparam int pos_width   = $clog2(digit_count);

    // word addresses on the bus
    localparam int addr_width = 2;
    localparam logic [addr_width-1:0] addr_value  = 2'd0;
    localparam logic [addr_width-1:0] addr_ctrl   = 2'd1;
    localparam logic [addr_width-1:0] addr_status = 2'd2;

    // CTRL fields
    localparam int ctrl_enable_bit = 0;
    localparam int ctrl_hex_bit    = 1;

    // STATUS fields
    localparam int status_busy_bit = 0;
    localparam int status_ovf_bit  = 1;

    // eight decimal digits wrap at this value
    localparam logic [value_width-1:0] value_modulus = 32'd100_000_000;

    // 1 ms scan step with a 100 MHz board clock
    localparam int default_tick_period = 100_000;

endpackage

// File: tests/tube_display_tb.sv
`timescale 1ns/1ns

module tube_display_tb import tube_pkg::*; ();

    localparam int tick_period = 4;
    localparam int clk_period  = 40;
    localparam int case_count  = 18;   // display windows checked over all tests
    localparam int timeout_ns  = case_count * 3 * digit_count * tick_period * clk_period
                                 + 20_000;
    localparam int ack_limit   = 16;
    localparam int idle_limit  = 40;

    localparam logic [value_width-1:0] ctrl_show = value_width'(1) << ctrl_enable_bit;
    localparam logic [value_width-1:0] ctrl_hex  = ctrl_show | (value_width'(1) << ctrl_hex_bit);
    localparam logic [value_width-1:0] busy_mask = value_width'(1) << status_busy_bit;
    localparam logic [value_width-1:0] ovf_mask  = value_width'(1) << status_ovf_bit;

    // active-low patterns, bit 0 is segment a
    localparam logic [seg_width-1:0] glyph_table [16] = '{
        7'b1000000, 7'b1111001, 7'b0100100, 7'b0110000,
        7'b0011001, 7'b0010010, 7'b0000010, 7'b1111000,
        7'b0000000, 7'b0010000, 7'b0001000, 7'b0000011,
        7'b1000110, 7'b0100001, 7'b0000110, 7'b0001110
    };

    logic                   clk_tube;
    logic                   rst_n;
    logic                   wb_cyc;
    logic                   wb_stb;
    logic                   wb_we;
    logic [addr_width-1:0]  wb_adr;
    logic [value_width-1:0] wb_dat_w;
    logic [sel_width-1:0]   wb_sel;
    logic [value_width-1:0] wb_dat_r;
    logic                   wb_ack;
    logic [seg_width-1:0]   seg_tube;
    logic [digit_count-1:0] seg_enable;

    int                   errors;
    int                   checks;
    logic [31:0]          rng_state;
    logic [seg_width-1:0] seen_glyph [digit_count];   // glyph per position, leftmost first

    tube_display_top #(
        .TICK_PERIOD(tick_period)
    ) u_dut (
        .clk_tube(clk_tube), .rst_n(rst_n),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w), .wb_sel(wb_sel), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
        .seg_tube(seg_tube), .seg_enable(seg_enable)
    );

    initial clk_tube = 1'b0;
    always #(clk_period / 2) clk_tube = ~clk_tube;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // glyph the tube should show at a position, from the value alone
    function automatic logic [seg_width-1:0] expected_glyph(input logic [31:0] v,
                                                            input logic hex, input int pos);
        logic [31:0]          rest;
        int                   idx;
        int                   top;
        int                   digit;
        logic [seg_width-1:0] g;
        idx   = digit_count - 1 - pos;
        rest  = v % 32'd100_000_000;
        top   = 0;
        digit = 0;
        for (int i = 0; i < digit_count; i++) begin
            if (rest % 10 != 0) begin
                top = i;   // highest nonzero digit so far
            end
            if (i == idx) begin
                digit = int'(rest % 10);
            end
            rest = rest / 10;
        end
        if (hex) begin
            g = glyph_table[4'(v >> (4 * idx))];
        end else if (idx > top) begin
            g = '1;   // leading zero
        end else begin
            g = glyph_table[digit];
        end
        return g;
    endfunction

    task automatic check_word(input logic [value_width-1:0] got,
                              input logic [value_width-1:0] exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t ns: %s read %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_glyph(input logic [seg_width-1:0] got,
                               input logic [seg_width-1:0] exp, input int pos, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t ns: %s position %0d shows %b, expected %b",
                     $time, what, pos, got, exp);
        end
    endtask

    task automatic check_enable(input logic [digit_count-1:0] got,
                                input logic [digit_count-1:0] exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    // one classic cycle, entered and left 2 ns after a rising edge
    task automatic bus_access(input logic we, input logic [addr_width-1:0] adr,
                              input logic [value_width-1:0] data,
                              input logic [sel_width-1:0] sel,
                              output logic [value_width-1:0] rdata);
        int waited;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = data;
        wb_sel   = sel;
        waited   = 0;
        do begin
            @(posedge clk_tube);
            #2;
            waited++;
        end while (!wb_ack && waited < ack_limit);
        if (!wb_ack) begin
            errors++;
            $display("no ack from address %0d within %0d cycles", adr, ack_limit);
        end else if (waited != 1) begin
            errors++;
            $display("ack from address %0d came after %0d cycles instead of one", adr, waited);
        end
        rdata  = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        @(posedge clk_tube);   // ack drops here
        #2;
        if (wb_ack) begin
            errors++;
            $display("ack from address %0d stayed high after the strobe fell", adr);
        end
    endtask

    task automatic wb_write(input logic [addr_width-1:0] adr,
                            input logic [value_width-1:0] data, input logic [sel_width-1:0] sel);
        logic [value_width-1:0] unused;
        bus_access(1'b1, adr, data, sel, unused);
    endtask

    task automatic wb_read(input logic [addr_width-1:0] adr, output logic [value_width-1:0] data);
        bus_access(1'b0, adr, '0, '1, data);
    endtask

    task automatic wait_idle();
        logic [value_width-1:0] status;
        int                     polls;
        polls = 0;
        do begin
            wb_read(addr_status, status);
            polls++;
        end while (status[status_busy_bit] && polls < idle_limit);
        if (status[status_busy_bit]) begin
            errors++;
            $display("converter still busy after %0d status polls", idle_limit);
        end
    endtask

    // scan monitor over one eight-tick window
    task automatic capture_window(output bit any_enable);
        logic [digit_count-1:0] seen;
        seen       = '0;
        any_enable = 1'b0;
        for (int p = 0; p < digit_count; p++) begin
            seen_glyph[p] = '1;
        end
        repeat (tick_period + 1) @(posedge clk_tube);   // let stale outputs go by
        #2;
        repeat (digit_count * tick_period) begin
            for (int b = 0; b < digit_count; b++) begin
                if (!seg_enable[b]) begin
                    any_enable                     = 1'b1;
                    seen_glyph[digit_count - 1 - b] = seg_tube;
                    seen[digit_count - 1 - b]       = 1'b1;
                end
            end
            @(posedge clk_tube);
            #2;
        end
        if (any_enable && seen != '1) begin
            errors++;
            $display("scan window missed positions, seen mask %b", seen);
        end
    endtask

    task automatic check_display(input logic [value_width-1:0] v, input logic hex,
                                 input string what);
        bit lit;
        capture_window(lit);
        if (!lit) begin
            errors++;
            $display("%s: no digit was enabled during the scan window", what);
        end
        for (int p = 0; p < digit_count; p++) begin
            check_glyph(seen_glyph[p], expected_glyph(v, hex, p), p, what);
        end
    endtask

    task automatic show_value(input logic [value_width-1:0] v, input string what);
        wb_write(addr_value, v, '1);
        wait_idle();
        check_display(v, 1'b0, what);
    endtask

    task automatic test_reset();
        logic [value_width-1:0] data;
        check_enable(seg_enable, '1, "seg_enable after reset");
        check_glyph(seg_tube, '1, 0, "seg_tube after reset");
        wb_read(addr_value, data);
        check_word(data, '0, "VALUE after reset");
        wb_read(addr_ctrl, data);
        check_word(data, '0, "CTRL after reset");
        wb_read(addr_status, data);
        check_word(data, '0, "STATUS after reset");
    endtask

    task automatic test_readback();
        logic [value_width-1:0] data;
        logic [value_width-1:0] first;
        logic [value_width-1:0] second;
        for (int i = 0; i < 3; i++) begin
            rng_state = xorshift(rng_state);
            wb_write(addr_value, rng_state, '1);
            wb_read(addr_value, data);
            check_word(data, rng_state, "VALUE readback");
        end
        first     = rng_state;
        rng_state = xorshift(rng_state);
        second    = rng_state;
        wb_write(addr_value, second, 4'b0101);   // bytes 0 and 2 only
        wb_read(addr_value, data);
        check_word(data, {first[31:24], second[23:16], first[15:8], second[7:0]},
                   "VALUE byte write");
        rng_state = xorshift(rng_state);
        first     = rng_state;
        wb_write(addr_ctrl, first, '1);
        wb_read(addr_ctrl, data);
        check_word(data, first, "CTRL readback");
        wb_write(addr_ctrl, '0, 4'b1000);
        wb_read(addr_ctrl, data);
        check_word(data, {8'h00, first[23:0]}, "CTRL byte write");
        wb_read(2'd3, data);
        check_word(data, '0, "unmapped read");
        wb_write(addr_ctrl, ctrl_show, '1);
    endtask

    task automatic test_decimal();
        logic [value_width-1:0] fixed [5];
        logic [value_width-1:0] v;
        fixed = '{32'd0, 32'd7, 32'd10, 32'd12_345_678, 32'd1000};
        wb_write(addr_ctrl, ctrl_show, '1);
        foreach (fixed[i]) begin
            show_value(fixed[i], $sformatf("decimal %0d", fixed[i]));
        end
        repeat (4) begin
            rng_state = xorshift(rng_state);
            v         = rng_state % 32'd100_000_000;
            show_value(v, $sformatf("decimal %0d", v));
        end
    endtask

    task automatic test_overflow();
        logic [value_width-1:0] big [3];
        logic [value_width-1:0] data;
        big = '{32'hffff_ffff, 32'd100_000_000, 32'd123_456_789};
        foreach (big[i]) begin
            show_value(big[i], $sformatf("overflow %h", big[i]));
            wb_read(addr_status, data);
            check_word(data, ovf_mask, "STATUS at or above 10^8");
        end
        show_value(32'd99_999_999, "largest in range");
        wb_read(addr_status, data);
        check_word(data, '0, "STATUS below 10^8");
    endtask

    task automatic test_hex();
        logic [value_width-1:0] v;
        wb_write(addr_ctrl, ctrl_hex, '1);
        wb_write(addr_value, 32'h0000_0a5f, '1);
        check_display(32'h0000_0a5f, 1'b1, "hex 00000a5f");
        repeat (2) begin
            rng_state = xorshift(rng_state);
            v         = rng_state;
            wb_write(addr_value, v, '1);
            check_display(v, 1'b1, $sformatf("hex %h", v));
        end
        wb_write(addr_ctrl, ctrl_show, '1);
    endtask

    task automatic test_disable_rewrite();
        logic [value_width-1:0] data;
        bit                     lit;
        wb_write(addr_ctrl, '0, '1);
        capture_window(lit);
        if (lit) begin
            errors++;
            $display("a digit enable went low while the display was disabled");
        end
        for (int p = 0; p < digit_count; p++) begin
            check_glyph(seen_glyph[p], '1, p, "disabled tube");
        end
        wb_write(addr_ctrl, ctrl_show, '1);
        wb_write(addr_value, 32'd4242, '1);
        wb_read(addr_status, data);
        check_word(data & busy_mask, busy_mask, "STATUS busy after first write");
        wb_write(addr_value, 32'd98_765_432, '1);   // restarts the conversion
        wait_idle();
        check_display(32'd98_765_432, 1'b0, "rewrite while busy");
    endtask

    initial begin
        errors    = 0;
        checks    = 0;
        rng_state = 32'h1f42dd26;
        rst_n     = 1'b0;
        wb_cyc    = 1'b0;
        wb_stb    = 1'b0;
        wb_we     = 1'b0;
        wb_adr    = '0;
        wb_dat_w  = '0;
        wb_sel    = '0;
        repeat (2) @(posedge clk_tube);
        #2;
        rst_n = 1'b1;
        test_reset();
        test_readback();
        test_decimal();
        test_overflow();
        test_hex();
        test_disable_rewrite();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    initial begin
        #(timeout_ns);
        $display("watchdog expired after %0d ns with tests still running", timeout_ns);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule
